//--- sysbus_cfg.svh
`ifndef SYSBUS_CFG_SVH
`define SYSBUS_CFG_SVH

// Byte address carried by cache requests and command words
`define SYSBUS_ADDR_W 16

// One bus beat
`define SYSBUS_WORD_W 32

// Cache line moved per transaction
`define SYSBUS_LINE_W 128

// Beats per line, lowest word goes first
`define SYSBUS_LINE_WORDS 4

// Bus masters, ic is master 0 and dc is master 1
`define SYSBUS_MASTERS 2

// Main memory depth in lines
// Index is the byte address without its line offset, wrapped to this depth
`define SYSBUS_MEM_LINES 256

`endif

//--- sysbus_pkg.sv
`default_nettype none

`include "sysbus_cfg.svh"

package sysbus_pkg;

   // Command beat, first valid word after a grant
   // Bit order from the top: write, id, count, spare, address
   typedef struct packed {
      // High for a line write
      logic write;
      // Requesting master
      logic id;
      // Data beats in the burst
      logic [2:0] count;
      // Unused, driven zero
      logic [`SYSBUS_WORD_W-`SYSBUS_ADDR_W-6:0] spare;
      // Byte address of the line
      logic [`SYSBUS_ADDR_W-1:0] addr;
   } bus_cmd_t;

   // One bus word, seen as a command or as a raw data beat
   typedef union packed {
      bus_cmd_t cmd;
      logic [`SYSBUS_WORD_W-1:0] data;
   } bus_word_u;

endpackage

`default_nettype wire

//--- bus_arbiter.sv
`default_nettype none

`include "sysbus_cfg.svh"

module bus_arbiter import sysbus_pkg::*; (
   input  logic bus_clk,
   input  logic reset,
   input  logic [`SYSBUS_MASTERS-1:0] br,
   input  bus_word_u [`SYSBUS_MASTERS-1:0] m_word,
   input  logic [`SYSBUS_MASTERS-1:0] m_valid,
   output logic [`SYSBUS_MASTERS-1:0] bg,
   output bus_word_u bus_word,
   output logic bus_valid
);

   localparam int idx_w = (`SYSBUS_MASTERS > 1) ? $clog2(`SYSBUS_MASTERS) : 1;

   // Current bus owner, meaningful while any bg is high
   logic [idx_w-1:0] owner;
   // Master with top priority in the next arbitration
   logic [idx_w-1:0] prio;
   logic [idx_w-1:0] pick;
   logic pick_ok;
   logic hold;

   // Owner keeps the bus as long as its request stays up
   assign hold = (|bg) && br[owner];

   // Round-robin search starting at prio
   // Walk from the far end so the nearest requester wins
   always_comb begin
      int idx;
      pick = prio;
      pick_ok = 1'b0;
      for (int k = `SYSBUS_MASTERS - 1; k >= 0; k--) begin
         idx = (int'(prio) + k) % `SYSBUS_MASTERS;
         if (br[idx]) begin
            pick = idx_w'(idx);
            pick_ok = 1'b1;
         end
      end
   end

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         bg <= '0;
         owner <= '0;
         prio <= '0;
      end else if (!hold) begin
         // Released or idle, regrant in one cycle
         bg <= '0;
         if (pick_ok) begin
            bg[pick] <= 1'b1;
            owner <= pick;
            // Granted master drops to lowest priority
            prio <= (int'(pick) == `SYSBUS_MASTERS - 1) ? '0 : pick + 1'b1;
         end
      end
   end

   // Shared bus carries the owner's beat only
   assign bus_word = m_word[owner];
   assign bus_valid = m_valid[owner] && (|bg);

endmodule

`default_nettype wire

//--- cache_bus_controller.sv
`default_nettype none

`include "sysbus_cfg.svh"

module cache_bus_controller import sysbus_pkg::*; #(
   parameter int master_id = 0
) (
   input  logic bus_clk,
   input  logic reset,
   // Cache side
   input  logic en,
   input  logic wr,
   input  logic [`SYSBUS_ADDR_W-1:0] a,
   input  logic [`SYSBUS_LINE_W-1:0] write_data,
   output logic [`SYSBUS_LINE_W-1:0] read_data,
   output logic r,
   // Arbiter side
   output logic br,
   input  logic bg,
   output bus_word_u m_word,
   output logic m_valid,
   // Slave responses
   input  logic [`SYSBUS_WORD_W-1:0] s_word,
   input  logic s_valid,
   input  logic done
);

   localparam int cnt_w = $clog2(`SYSBUS_LINE_WORDS);
   localparam logic [cnt_w-1:0] last_beat = cnt_w'(`SYSBUS_LINE_WORDS - 1);

   typedef enum logic [2:0] {
      st_idle,
      st_req,
      st_cmd,
      st_data,
      st_resp
   } state_t;

   state_t state;
   logic [cnt_w-1:0] cnt;

   // Request latched on en
   logic wr_q;
   logic [`SYSBUS_ADDR_W-1:0] a_q;
   // Shared line buffer
   // Write data shifts out of the bottom, read beats shift in at the top
   logic [`SYSBUS_LINE_W-1:0] line_q;

   // Slave beats count only while this master owns the bus
   logic resp_beat;
   logic resp_done;

   assign resp_beat = bg && s_valid;
   assign resp_done = bg && done;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state <= st_idle;
         cnt <= '0;
         br <= 1'b0;
         r <= 1'b1;
      end else begin
         case (state)
            st_idle: begin
               if (en) begin
                  state <= st_req;
                  br <= 1'b1;
                  r <= 1'b0;
               end
            end
            st_req: begin
               // Wait out the other master
               if (bg) begin
                  state <= st_cmd;
               end
            end
            st_cmd: begin
               cnt <= '0;
               state <= wr_q ? st_data : st_resp;
            end
            st_data: begin
               cnt <= cnt + 1'b1;
               if (cnt == last_beat) begin
                  state <= st_resp;
               end
            end
            st_resp: begin
               // br falls and r rises the cycle after done
               if (resp_done) begin
                  state <= st_idle;
                  br <= 1'b0;
                  r <= 1'b1;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if (state == st_idle && en) begin
         wr_q <= wr;
         a_q <= a;
         line_q <= write_data;
      end else if (state == st_data) begin
         line_q <= line_q >> `SYSBUS_WORD_W;
      end else if (state == st_resp && resp_beat) begin
         // Lowest word arrives first and ends up at the bottom
         line_q <= {s_word, line_q[`SYSBUS_LINE_W-1:`SYSBUS_WORD_W]};
      end
   end

   // Outgoing beat, command then optional write data
   always_comb begin
      m_word = '0;
      m_valid = 1'b0;
      if (state == st_cmd) begin
         m_word.cmd.write = wr_q;
         m_word.cmd.id = 1'(master_id);
         m_word.cmd.count = 3'(`SYSBUS_LINE_WORDS);
         m_word.cmd.addr = a_q;
         m_valid = 1'b1;
      end else if (state == st_data) begin
         m_word.data = line_q[`SYSBUS_WORD_W-1:0];
         m_valid = 1'b1;
      end
   end

   assign read_data = line_q;

endmodule

`default_nettype wire

//--- mem_bus_controller.sv
`default_nettype none

`include "sysbus_cfg.svh"

module mem_bus_controller import sysbus_pkg::*; (
   input  logic bus_clk,
   input  logic reset,
   // Shared bus from the arbiter
   input  bus_word_u bus_word,
   input  logic bus_valid,
   // Responses back to the masters
   output logic [`SYSBUS_WORD_W-1:0] s_word,
   output logic s_valid,
   output logic done,
   // Main memory port
   output logic mem_en,
   output logic mem_wr,
   output logic [$clog2(`SYSBUS_MEM_LINES)-1:0] mem_a,
   output logic [`SYSBUS_LINE_W-1:0] mem_wdata,
   input  logic [`SYSBUS_LINE_W-1:0] mem_rdata
);

   localparam int cnt_w = $clog2(`SYSBUS_LINE_WORDS);
   localparam int mem_a_w = $clog2(`SYSBUS_MEM_LINES);
   // Byte offset inside one line
   localparam int off_w = $clog2(`SYSBUS_LINE_W / 8);
   localparam logic [cnt_w-1:0] last_beat = cnt_w'(`SYSBUS_LINE_WORDS - 1);

   typedef enum logic [2:0] {
      st_idle,
      st_wdata,
      st_wmem,
      st_rmem,
      st_rload,
      st_rsend
   } state_t;

   state_t state;
   logic [cnt_w-1:0] cnt;
   // Assembled write line or read line being sent
   logic [`SYSBUS_LINE_W-1:0] line_q;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state <= st_idle;
         cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               // First valid beat of a tenure is always a command
               if (bus_valid) begin
                  cnt <= '0;
                  state <= bus_word.cmd.write ? st_wdata : st_rmem;
               end
            end
            st_wdata: begin
               if (bus_valid) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == last_beat) begin
                     state <= st_wmem;
                  end
               end
            end
            // Line write, done goes out this cycle
            st_wmem: state <= st_idle;
            st_rmem: state <= st_rload;
            st_rload: begin
               cnt <= '0;
               state <= st_rsend;
            end
            st_rsend: begin
               cnt <= cnt + 1'b1;
               if (cnt == last_beat) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      // Line index, upper address bits wrap onto the memory depth
      if (state == st_idle && bus_valid) begin
         mem_a <= bus_word.cmd.addr[off_w +: mem_a_w];
      end
      if (state == st_wdata && bus_valid) begin
         line_q <= {bus_word.data, line_q[`SYSBUS_LINE_W-1:`SYSBUS_WORD_W]};
      end else if (state == st_rload) begin
         // Registered RAM output is valid here
         line_q <= mem_rdata;
      end else if (state == st_rsend) begin
         line_q <= line_q >> `SYSBUS_WORD_W;
      end
   end

   assign s_word = line_q[`SYSBUS_WORD_W-1:0];
   assign s_valid = (state == st_rsend);
   // Done rides on the last read beat or on the line write
   assign done = (state == st_wmem) || (state == st_rsend && cnt == last_beat);
   assign mem_en = (state == st_rmem) || (state == st_wmem);
   assign mem_wr = (state == st_wmem);
   assign mem_wdata = line_q;

endmodule

`default_nettype wire

//--- main_memory.sv
`default_nettype none

`include "sysbus_cfg.svh"

module main_memory (
   input  logic bus_clk,
   input  logic mem_en,
   input  logic mem_wr,
   input  logic [$clog2(`SYSBUS_MEM_LINES)-1:0] mem_a,
   input  logic [`SYSBUS_LINE_W-1:0] mem_wdata,
   output logic [`SYSBUS_LINE_W-1:0] mem_rdata
);

   // One full cache line per entry
   logic [`SYSBUS_LINE_W-1:0] mem [`SYSBUS_MEM_LINES];

   // Write in the enable cycle
   // Read data shows up one cycle after the enable
   always_ff @(posedge bus_clk) begin
      if (mem_en) begin
         if (mem_wr) begin
            mem[mem_a] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_a];
         end
      end
   end

endmodule

`default_nettype wire

//--- full_memory.sv
`default_nettype none

`include "sysbus_cfg.svh"

module full_memory import sysbus_pkg::*; (
   input  logic bus_clk,
   input  logic reset,
   // Data cache port
   input  logic dc_en,
   input  logic dc_wr,
   input  logic [`SYSBUS_ADDR_W-1:0] dc_a,
   input  logic [`SYSBUS_LINE_W-1:0] dc_write_data,
   output logic [`SYSBUS_LINE_W-1:0] dc_read_data,
   output logic dc_r,
   // Instruction cache port
   input  logic ic_en,
   input  logic ic_wr,
   input  logic [`SYSBUS_ADDR_W-1:0] ic_a,
   input  logic [`SYSBUS_LINE_W-1:0] ic_write_data,
   output logic [`SYSBUS_LINE_W-1:0] ic_read_data,
   output logic ic_r
);

   // Arbitration and master beats
   logic [`SYSBUS_MASTERS-1:0] br;
   logic [`SYSBUS_MASTERS-1:0] bg;
   bus_word_u [`SYSBUS_MASTERS-1:0] m_word;
   logic [`SYSBUS_MASTERS-1:0] m_valid;

   // Shared bus and slave responses
   bus_word_u bus_word;
   logic bus_valid;
   logic [`SYSBUS_WORD_W-1:0] s_word;
   logic s_valid;
   logic done;

   // Memory controller to RAM
   logic mem_en;
   logic mem_wr;
   logic [$clog2(`SYSBUS_MEM_LINES)-1:0] mem_a;
   logic [`SYSBUS_LINE_W-1:0] mem_wdata;
   logic [`SYSBUS_LINE_W-1:0] mem_rdata;

   bus_arbiter arbiter_u (
      .bus_clk(bus_clk), .reset(reset), .br(br), .m_word(m_word),
      .m_valid(m_valid), .bg(bg), .bus_word(bus_word), .bus_valid(bus_valid)
   );

   // ic port is master 0
   cache_bus_controller #(.master_id(0)) icache_port (
      .bus_clk(bus_clk), .reset(reset), .en(ic_en), .wr(ic_wr), .a(ic_a),
      .write_data(ic_write_data), .read_data(ic_read_data), .r(ic_r),
      .br(br[0]), .bg(bg[0]), .m_word(m_word[0]), .m_valid(m_valid[0]),
      .s_word(s_word), .s_valid(s_valid), .done(done)
   );

   // dc port is master 1
   cache_bus_controller #(.master_id(1)) dcache_port (
      .bus_clk(bus_clk), .reset(reset), .en(dc_en), .wr(dc_wr), .a(dc_a),
      .write_data(dc_write_data), .read_data(dc_read_data), .r(dc_r),
      .br(br[1]), .bg(bg[1]), .m_word(m_word[1]), .m_valid(m_valid[1]),
      .s_word(s_word), .s_valid(s_valid), .done(done)
   );

   mem_bus_controller mem_bus_controller_u (
      .bus_clk(bus_clk), .reset(reset), .bus_word(bus_word), .bus_valid(bus_valid),
      .s_word(s_word), .s_valid(s_valid), .done(done), .mem_en(mem_en),
      .mem_wr(mem_wr), .mem_a(mem_a), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

   main_memory main_memory_u (
      .bus_clk(bus_clk), .mem_en(mem_en), .mem_wr(mem_wr), .mem_a(mem_a),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

endmodule

`default_nettype wire

//--- bus_checker.sv
`default_nettype none

`include "sysbus_cfg.svh"

module bus_checker (
   input  logic bus_clk,
   input  logic reset,
   input  logic ic_en,
   input  logic ic_r,
   input  logic [`SYSBUS_LINE_W-1:0] ic_read_data,
   input  logic dc_en,
   input  logic dc_r,
   input  logic [`SYSBUS_LINE_W-1:0] dc_read_data,
   output int mismatch_count,
   output int fault_count,
   output logic all_done
);

   localparam int max_ops = 64;
   localparam int cols = 5;
   // One foreign tenure plus our own fits well inside this
   localparam int stall_limit = 50;

   logic [`SYSBUS_LINE_W-1:0] stim [cols*max_ops];
   // Stimulus line of each operation, per port in issue order
   int ops [2][max_ops];
   int op_total [2];
   int op_next [2];
   logic r_q [2];
   int low_cycles [2];
   logic reset_q;

   initial begin
      int n;
      int port;
      mismatch_count = 0;
      fault_count = 0;
      all_done = 1'b0;
      reset_q = 1'b0;
      op_total[0] = 0;
      op_total[1] = 0;
      op_next[0] = 0;
      op_next[1] = 0;
      $readmemh("full_memory_stimulus.txt", stim);
      n = 0;
      while (n < max_ops && !$isunknown(stim[cols*n])) begin
         port = int'(stim[cols*n]);
         // Sync lines carry no operation
         if (port < 2) begin
            ops[port][op_total[port]] = n;
            op_total[port]++;
         end
         n++;
      end
   end

   function automatic string port_name(input int port);
      return (port == 1) ? "dc" : "ic";
   endfunction

   task automatic watch_port(input int port, input logic en, input logic r,
                             input logic [`SYSBUS_LINE_W-1:0] data);
      int line;
      logic [`SYSBUS_LINE_W-1:0] expected;
      if (en && !r) begin
         fault_count++;
         $display("Error: %s port got en while its r was low", port_name(port));
      end
      if (r) begin
         low_cycles[port] = 0;
      end else begin
         low_cycles[port]++;
         if (low_cycles[port] == stall_limit) begin
            fault_count++;
            $display("Error: %s port stayed not ready for %0d cycles", port_name(port),
                     stall_limit);
         end
      end
      // Rising r closes the oldest open operation of this port
      if (r && !r_q[port]) begin
         if (op_next[port] >= op_total[port]) begin
            fault_count++;
            $display("Error: %s port finished an operation that was never issued",
                     port_name(port));
         end else begin
            line = ops[port][op_next[port]];
            op_next[port]++;
            expected = stim[cols*line+4];
            // Only reads return a line
            if (stim[cols*line+1][0] == 1'b0 && data !== expected) begin
               mismatch_count++;
               $display("Mismatch: %s_read_data at stimulus line %0d expected 0x%h got 0x%h",
                        port_name(port), line, expected, data);
            end
         end
      end
      r_q[port] = r;
   endtask

   always @(posedge bus_clk) begin
      if (reset) begin
         r_q[0] = 1'b1;
         r_q[1] = 1'b1;
         low_cycles[0] = 0;
         low_cycles[1] = 0;
         reset_q = 1'b1;
         all_done = 1'b0;
      end else begin
         // Both ports leave reset ready
         if (reset_q && !(ic_r === 1'b1 && dc_r === 1'b1)) begin
            fault_count++;
            $display("Error: r outputs were not both high after reset");
         end
         reset_q = 1'b0;
         watch_port(0, ic_en, ic_r, ic_read_data);
         watch_port(1, dc_en, dc_r, dc_read_data);
         all_done = (op_next[0] == op_total[0]) && (op_next[1] == op_total[1]) && ic_r && dc_r;
      end
   end

endmodule

`default_nettype wire

//--- tb_full_memory.sv
`default_nettype none

`include "sysbus_cfg.svh"

module tb_full_memory;

   // Five hex columns per stimulus line
   localparam int max_ops = 64;
   localparam int cols = 5;

   logic bus_clk;
   logic reset;
   logic dc_en;
   logic dc_wr;
   logic ic_en;
   logic ic_wr;
   logic [`SYSBUS_ADDR_W-1:0] dc_a;
   logic [`SYSBUS_ADDR_W-1:0] ic_a;
   logic [`SYSBUS_LINE_W-1:0] dc_write_data;
   logic [`SYSBUS_LINE_W-1:0] ic_write_data;
   logic [`SYSBUS_LINE_W-1:0] dc_read_data;
   logic [`SYSBUS_LINE_W-1:0] ic_read_data;
   logic dc_r;
   logic ic_r;
   int mismatch_count;
   int fault_count;
   logic all_done;

   logic [`SYSBUS_LINE_W-1:0] stim [cols*max_ops];
   int nlines;
   int cycles;
   int cycle_limit;
   // Sync points reached so far by each driver
   int sync_count [2];

   full_memory uut (.*);

   bus_checker bus_checker_u (.*);

   initial begin
      bus_clk = 1'b0;
      forever #4 bus_clk = ~bus_clk;
   end

   // Returns right after an edge at which r was already high
   task automatic wait_ready(input int port);
      @(posedge bus_clk);
      while (!(port == 1 ? dc_r : ic_r)) begin
         @(posedge bus_clk);
      end
   endtask

   task automatic run_port(input int port);
      int k;
      int syncs;
      logic just_synced;
      syncs = 0;
      just_synced = 1'b0;
      for (k = 0; k < nlines; k++) begin
         if (stim[cols*k] == 2) begin
            // Both ports go idle before either one moves on
            wait_ready(port);
            syncs++;
            sync_count[port] = syncs;
            wait (sync_count[0] >= syncs && sync_count[1] >= syncs);
            just_synced = 1'b1;
         end else if (stim[cols*k] == port) begin
            // First operation after a sync point requests on the same edge as the other port
            if (!just_synced) begin
               repeat ($urandom % 6) @(posedge bus_clk);
            end
            just_synced = 1'b0;
            wait_ready(port);
            if (port == 1) begin
               dc_en <= 1'b1;
               dc_wr <= stim[cols*k+1][0];
               dc_a <= stim[cols*k+2][`SYSBUS_ADDR_W-1:0];
               dc_write_data <= stim[cols*k+3];
            end else begin
               ic_en <= 1'b1;
               ic_wr <= stim[cols*k+1][0];
               ic_a <= stim[cols*k+2][`SYSBUS_ADDR_W-1:0];
               ic_write_data <= stim[cols*k+3];
            end
            // One-cycle en pulse
            @(posedge bus_clk);
            if (port == 1) begin
               dc_en <= 1'b0;
            end else begin
               ic_en <= 1'b0;
            end
         end
      end
      wait_ready(port);
   endtask

   task automatic report_counts();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
   endtask

   // Cycle budget scales with the number of stimulus lines
   initial begin
      cycles = 0;
      while (cycle_limit == 0 || cycles < cycle_limit) begin
         @(negedge bus_clk);
         cycles++;
      end
      $display("Timeout after %0d cycles with operations still open", cycles);
      report_counts();
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      void'($urandom(46002));
      cycle_limit = 0;
      reset = 1'b1;
      dc_en = 1'b0;
      dc_wr = 1'b0;
      dc_a = '0;
      dc_write_data = '0;
      ic_en = 1'b0;
      ic_wr = 1'b0;
      ic_a = '0;
      ic_write_data = '0;
      sync_count[0] = 0;
      sync_count[1] = 0;
      $readmemh("full_memory_stimulus.txt", stim);
      nlines = 0;
      while (nlines < max_ops && !$isunknown(stim[cols*nlines])) begin
         nlines++;
      end
      cycle_limit = 60 * nlines + 200;
      repeat (16) @(posedge bus_clk);
      reset <= 1'b0;
      fork
         run_port(0);
         run_port(1);
      join
      while (!all_done) begin
         @(negedge bus_clk);
      end
      report_counts();
      if (mismatch_count == 0 && fault_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- full_memory_stimulus.txt
// Columns: port wr addr write_data expected_read_data, all hex
// Port 0 is ic, 1 is dc, 2 waits until both ports are idle
1 1 0100 a1000003a1000002a1000001a1000000 0
1 0 0100 0 a1000003a1000002a1000001a1000000
0 1 0200 b2000003b2000002b2000001b2000000 0
0 0 0200 0 b2000003b2000002b2000001b2000000
2 0 0 0 0
1 1 0300 c3000003c3000002c3000001c3000000 0
0 1 0400 d4000003d4000002d4000001d4000000 0
2 0 0 0 0
0 0 0300 0 c3000003c3000002c3000001c3000000
1 0 0400 0 d4000003d4000002d4000001d4000000
2 0 0 0 0
1 1 0500 e5000003e5000002e5000001e5000000 0
1 1 0510 f6000003f6000002f6000001f6000000 0
1 1 0520 17000003170000021700000117000000 0
0 1 0a30 28000003280000022800000128000000 0
0 1 1a30 39000003390000023900000139000000 0
1 0 0500 0 e5000003e5000002e5000001e5000000
1 0 0510 0 f6000003f6000002f6000001f6000000
1 0 0520 0 17000003170000021700000117000000
0 0 0a30 0 39000003390000023900000139000000
0 0 fa30 0 39000003390000023900000139000000

//--- build.f
+incdir+.
sysbus_pkg.sv
bus_arbiter.sv
cache_bus_controller.sv
mem_bus_controller.sv
main_memory.sv
full_memory.sv
bus_checker.sv
tb_full_memory.sv

//--- Bender.yml
package:
  name: full_memory

sources:
  - include_dirs:
      - .
    files:
      - sysbus_pkg.sv
      - bus_arbiter.sv
      - cache_bus_controller.sv
      - mem_bus_controller.sv
      - main_memory.sv
      - full_memory.sv
  - target: test
    include_dirs:
      - .
    files:
      - bus_checker.sv
      - tb_full_memory.sv
